//--- include/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define WORD_SIZE 16
`define REG_SIZE  2
`define NUM_REGS  4
`define IMM_SIZE  8

// opcode field in inst[15:12]
`define OP_RTYPE 4'd15
`define OP_ADI   4'd4
`define OP_ORI   4'd5
`define OP_LHI   4'd6
`define OP_LWD   4'd7
`define OP_SWD   4'd8

// funct field of r-type in inst[5:0]
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_NOT 6'd4
`define FN_TCP 6'd5
`define FN_SHL 6'd6
`define FN_SHR 6'd7
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`define NOP_INST 16'h5000   // ori $0, $0, 0

`endif

//--- verilog/cpu_pkg.sv
`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`WORD_SIZE-1:0] word_t;
    typedef logic [`WORD_SIZE-1:0] inst_t;
    typedef logic [`REG_SIZE-1:0]  reg_idx_t;
    typedef logic [2:0]            alu_func_t;   // low bits of funct
    typedef logic [1:0]            fwd_sel_t;    // none, mem or wb

    typedef enum logic {
        FETCH_RUN,
        FETCH_HALT
    } fetch_state_t;

endpackage

//--- verilog/alu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu
    import cpu_pkg::*;
(
    input  word_t     a,
    input  word_t     b,
    input  alu_func_t func,
    output word_t     result
);

    always_comb begin
        case ({3'b000, func})
            `FN_ADD: result = a + b;
            `FN_SUB: result = a - b;
            `FN_AND: result = a & b;
            `FN_ORR: result = a | b;
            `FN_NOT: result = ~a;
            `FN_TCP: result = -a;
            `FN_SHL: result = {a[`WORD_SIZE-2:0], 1'b0};
            `FN_SHR: result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};   // sign kept
            default: result = '0;
        endcase
    end

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module register_file
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t read1,
    input  reg_idx_t read2,
    input  reg_idx_t dest,
    input  word_t    write_data,
    input  logic     reg_write,
    output word_t    read_out1,
    output word_t    read_out2
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_write) begin
            regs[dest] <= write_data;
        end
    end

    // writeback in the same cycle goes straight to the reads
    assign read_out1 = (reg_write && dest == read1) ? write_data : regs[read1];
    assign read_out2 = (reg_write && dest == read2) ? write_data : regs[read2];

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module fetch_unit
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  m1_ready,
    input  inst_t data1,
    input  logic  stall,
    input  logic  mem_ready,
    input  logic  halt_seen,
    output logic  read_m1,
    output word_t address1,
    output inst_t if_inst,
    output logic  if_valid
);

    fetch_state_t state;
    word_t        pc;
    logic         fetch_ok;
    logic         take_inst;
    logic         load_ifid;

    assign fetch_ok  = read_m1 && m1_ready;
    assign take_inst = fetch_ok && !halt_seen;   // fetch after hlt is dropped
    assign load_ifid = mem_ready && !stall;
    assign address1  = pc;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state    <= FETCH_RUN;
            read_m1  <= 1'b0;
            pc       <= '0;
            if_valid <= 1'b0;
        end else begin
            if (mem_ready && halt_seen) begin
                state   <= FETCH_HALT;
                read_m1 <= 1'b0;
            end else begin
                read_m1 <= (state == FETCH_RUN);
            end
            if (load_ifid) begin
                if_valid <= take_inst;
                if (take_inst) begin
                    pc <= pc + word_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ifid) begin
            if_inst <= take_inst ? data1 : `NOP_INST;
        end
    end

    // once halted, port 1 stays quiet until reset
    assert property (@(posedge clk) disable iff (reset_n)
        (state == FETCH_HALT) |-> !read_m1);

endmodule

//--- verilog/decode_unit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module decode_unit
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  inst_t     if_inst,
    input  logic      if_valid,
    input  logic      mem_ready,
    input  reg_idx_t  wb_dest,
    input  word_t     wb_data,
    input  logic      wb_write,
    output logic      stall,
    output logic      halt_seen,
    output word_t     id_rs_val,
    output word_t     id_rt_val,
    output word_t     id_imm,
    output reg_idx_t  id_rs,
    output reg_idx_t  id_rt,
    output reg_idx_t  id_dest,
    output alu_func_t id_func,
    output logic      id_alu_src,
    output logic      id_lhi,
    output logic      id_mem_read,
    output logic      id_mem_write,
    output logic      id_reg_write,
    output logic      id_wwd,
    output logic      id_halt,
    output logic      id_valid
);

    logic [3:0]           opcode;
    logic [5:0]           funct;
    logic [`IMM_SIZE-1:0] imm8;
    reg_idx_t             rs;
    reg_idx_t             rt;
    reg_idx_t             rd;
    word_t                rs_val;
    word_t                rt_val;
    word_t                imm_ext;
    reg_idx_t             dest;
    alu_func_t            func;
    logic                 alu_src, lhi, mem_read, mem_write, reg_write, wwd, halt;
    logic                 use_rs, use_rt;
    logic                 load_idex;

    assign opcode = if_inst[15:12];
    assign rs     = if_inst[11:10];
    assign rt     = if_inst[9:8];
    assign rd     = if_inst[7:6];
    assign funct  = if_inst[5:0];
    assign imm8   = if_inst[`IMM_SIZE-1:0];

    register_file regs (
        .clk       (clk),
        .reset_n   (reset_n),
        .read1     (rs),
        .read2     (rt),
        .dest      (wb_dest),
        .write_data(wb_data),
        .reg_write (wb_write),
        .read_out1 (rs_val),
        .read_out2 (rt_val)
    );

    ////////////////////////////////////////////////////////////
    // control decode

    always_comb begin
        dest      = rt;
        func      = alu_func_t'(`FN_ADD);
        imm_ext   = {{(`WORD_SIZE-`IMM_SIZE){imm8[`IMM_SIZE-1]}}, imm8};
        alu_src   = 1'b0;
        lhi       = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        wwd       = 1'b0;
        halt      = 1'b0;
        use_rs    = 1'b1;
        use_rt    = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                dest = rd;
                if (funct[5:3] == 3'b000) begin   // alu group
                    func      = funct[2:0];
                    reg_write = 1'b1;
                    use_rt    = 1'b1;
                end else if (funct == `FN_WWD) begin
                    wwd = 1'b1;
                end else if (funct == `FN_HLT) begin
                    halt   = 1'b1;
                    use_rs = 1'b0;
                end
            end
            `OP_ADI: begin
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            `OP_ORI: begin
                func      = alu_func_t'(`FN_ORR);
                imm_ext   = {{(`WORD_SIZE-`IMM_SIZE){1'b0}}, imm8};
                alu_src   = 1'b1;
                reg_write = 1'b1;
            end
            `OP_LHI: begin
                func      = alu_func_t'(`FN_ORR);
                imm_ext   = {imm8, {(`WORD_SIZE-`IMM_SIZE){1'b0}}};
                alu_src   = 1'b1;
                lhi       = 1'b1;
                reg_write = 1'b1;
                use_rs    = 1'b0;
            end
            `OP_LWD: begin
                alu_src   = 1'b1;
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            `OP_SWD: begin
                alu_src   = 1'b1;
                mem_write = 1'b1;
                use_rt    = 1'b1;
            end
            default: begin
                use_rs = 1'b0;   // dropped opcodes act as nops
            end
        endcase
    end

    // load in ex feeding the instruction in id
    assign stall = if_valid && id_mem_read &&
                   ((use_rs && id_dest == rs) || (use_rt && id_dest == rt));
    assign halt_seen = if_valid && halt;
    assign load_idex = if_valid && !stall;

    ////////////////////////////////////////////////////////////
    // ID/EX register

    always_ff @(posedge clk) begin
        if (reset_n) begin
            id_valid     <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_reg_write <= 1'b0;
            id_wwd       <= 1'b0;
            id_halt      <= 1'b0;
        end else if (mem_ready) begin
            id_valid     <= load_idex;
            id_mem_read  <= load_idex && mem_read;
            id_mem_write <= load_idex && mem_write;
            id_reg_write <= load_idex && reg_write;
            id_wwd       <= load_idex && wwd;
            id_halt      <= load_idex && halt;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ready) begin
            id_rs_val  <= rs_val;
            id_rt_val  <= rt_val;
            id_imm     <= imm_ext;
            id_rs      <= rs;
            id_rt      <= rt;
            id_dest    <= dest;
            id_func    <= func;
            id_alu_src <= alu_src;
            id_lhi     <= lhi;
        end else begin
            // writeback that lands while ex is held
            if (wb_write && wb_dest == id_rs) begin
                id_rs_val <= wb_data;
            end
            if (wb_write && wb_dest == id_rt) begin
                id_rt_val <= wb_data;
            end
        end
    end

endmodule

//--- verilog/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import cpu_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      mem_ready,
    input  word_t     id_rs_val,
    input  word_t     id_rt_val,
    input  word_t     id_imm,
    input  reg_idx_t  id_rs,
    input  reg_idx_t  id_rt,
    input  reg_idx_t  id_dest,
    input  alu_func_t id_func,
    input  logic      id_alu_src,
    input  logic      id_lhi,
    input  logic      id_mem_read,
    input  logic      id_mem_write,
    input  logic      id_reg_write,
    input  logic      id_wwd,
    input  logic      id_halt,
    input  logic      id_valid,
    input  reg_idx_t  wb_dest,
    input  word_t     wb_data,
    input  logic      wb_write,
    output word_t     ex_alu_out,
    output word_t     ex_store_data,
    output word_t     ex_wwd_val,
    output reg_idx_t  ex_dest,
    output logic      ex_mem_read,
    output logic      ex_mem_write,
    output logic      ex_reg_write,
    output logic      ex_wwd,
    output logic      ex_halt,
    output logic      ex_valid
);

    localparam fwd_sel_t FWD_NONE = 2'd0;
    localparam fwd_sel_t FWD_MEM  = 2'd1;
    localparam fwd_sel_t FWD_WB   = 2'd2;

    fwd_sel_t sel_a;
    fwd_sel_t sel_b;
    word_t    fwd_a;
    word_t    fwd_b;
    word_t    op_a;
    word_t    op_b;
    word_t    alu_result;

    function automatic word_t fwd_mux(fwd_sel_t sel, word_t reg_val, word_t mem_val,
                                      word_t wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return reg_val;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // forwarding where the newer ex/mem wins

    assign sel_a = (ex_reg_write && ex_dest == id_rs) ? FWD_MEM :
                   (wb_write && wb_dest == id_rs)     ? FWD_WB  : FWD_NONE;
    assign sel_b = (ex_reg_write && ex_dest == id_rt) ? FWD_MEM :
                   (wb_write && wb_dest == id_rt)     ? FWD_WB  : FWD_NONE;

    assign fwd_a = fwd_mux(sel_a, id_rs_val, ex_alu_out, wb_data);
    assign fwd_b = fwd_mux(sel_b, id_rt_val, ex_alu_out, wb_data);

    assign op_a = id_lhi ? '0 : fwd_a;        // lhi ignores rs
    assign op_b = id_alu_src ? id_imm : fwd_b;

    alu u_alu (
        .a     (op_a),
        .b     (op_b),
        .func  (id_func),
        .result(alu_result)
    );

    ////////////////////////////////////////////////////////////
    // EX/MEM register

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ex_valid     <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_wwd       <= 1'b0;
            ex_halt      <= 1'b0;
        end else if (mem_ready) begin
            ex_valid     <= id_valid;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_reg_write <= id_reg_write;
            ex_wwd       <= id_wwd;
            ex_halt      <= id_halt;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ready) begin
            ex_alu_out    <= alu_result;
            ex_store_data <= fwd_b;    // rt of a store
            ex_wwd_val    <= fwd_a;
            ex_dest       <= id_dest;
        end
    end

    // decode never marks one instruction as both load and store
    assert property (@(posedge clk) disable iff (reset_n)
        !(ex_mem_read && ex_mem_write));

endmodule

//--- verilog/mem_wb_unit.sv
`timescale 1ns/1ps

module mem_wb_unit
    import cpu_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  word_t    ex_alu_out,
    input  word_t    ex_store_data,
    input  word_t    ex_wwd_val,
    input  reg_idx_t ex_dest,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    input  logic     ex_reg_write,
    input  logic     ex_wwd,
    input  logic     ex_halt,
    input  logic     ex_valid,
    input  logic     m2_ready,
    input  word_t    read_data,
    output logic     read_m2,
    output logic     write_m2,
    output word_t    address2,
    output word_t    write_data,
    output logic     mem_ready,
    output reg_idx_t wb_dest,
    output word_t    wb_data,
    output logic     wb_write,
    output word_t    output_port,
    output word_t    num_inst,
    output logic     is_halted
);

    assign read_m2    = ex_mem_read;
    assign write_m2   = ex_mem_write;
    assign address2   = ex_alu_out;
    assign write_data = ex_store_data;
    assign mem_ready  = m2_ready || !(ex_mem_read || ex_mem_write);

    ////////////////////////////////////////////////////////////
    // MEM/WB register and retire side effects

    always_ff @(posedge clk) begin
        if (reset_n) begin
            wb_write    <= 1'b0;
            output_port <= '0;
            num_inst    <= '0;
            is_halted   <= 1'b0;
        end else begin
            wb_write <= mem_ready && ex_reg_write;   // bubble while port 2 waits
            if (mem_ready && ex_valid) begin
                if (ex_wwd) begin
                    output_port <= ex_wwd_val;
                end
                if (ex_halt) begin
                    is_halted <= 1'b1;
                end else begin
                    num_inst <= num_inst + word_t'(1);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_ready) begin
            wb_dest <= ex_dest;
            wb_data <= ex_mem_read ? read_data : ex_alu_out;
        end
    end

    // a pending store keeps its address and data until accepted
    assert property (@(posedge clk) disable iff (reset_n)
        (write_m2 && !m2_ready) |=> (write_m2 && $stable(address2) && $stable(write_data)));

endmodule

//--- verilog/cpu.sv
`timescale 1ns/1ps

module cpu
    import cpu_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    output logic  read_m1,
    output word_t address1,
    input  inst_t data1,
    input  logic  m1_ready,
    output logic  read_m2,
    output logic  write_m2,
    output word_t address2,
    input  word_t read_data,
    output word_t write_data,
    input  logic  m2_ready,
    output word_t num_inst,
    output word_t output_port,
    output logic  is_halted
);

    // if/id and pipeline control
    inst_t     if_inst;
    logic      if_valid;
    logic      stall;
    logic      halt_seen;
    logic      mem_ready;

    // id/ex
    word_t     id_rs_val, id_rt_val, id_imm;
    reg_idx_t  id_rs, id_rt, id_dest;
    alu_func_t id_func;
    logic      id_alu_src, id_lhi, id_mem_read, id_mem_write;
    logic      id_reg_write, id_wwd, id_halt, id_valid;

    // ex/mem
    word_t     ex_alu_out, ex_store_data, ex_wwd_val;
    reg_idx_t  ex_dest;
    logic      ex_mem_read, ex_mem_write, ex_reg_write, ex_wwd, ex_halt, ex_valid;

    // writeback
    reg_idx_t  wb_dest;
    word_t     wb_data;
    logic      wb_write;

    fetch_unit   u_fetch   (.*);
    decode_unit  u_decode  (.*);
    execute_unit u_execute (.*);
    mem_wb_unit  u_mem_wb  (.*);

endmodule

//--- verif/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb
    import cpu_pkg::*;
();

    localparam int TIMEOUT  = 5000;
    localparam int PROG_LEN = 40;

    logic  clk;
    logic  reset_n;
    logic  m1_ready;
    logic  m2_ready;
    inst_t data1;
    word_t read_data;
    logic  read_m1, read_m2, write_m2, is_halted;
    word_t address1, address2, write_data, num_inst, output_port;

    inst_t       imem [256];
    word_t       dmem [256];
    word_t       dmem_init [256];
    word_t       model_mem [256];
    word_t       retire_out [256];   // output_port after the k-th retire
    word_t       final_out;
    int          model_count, model_stores, store_count;
    int          model_loads, load_count;
    logic [31:0] lfsr;
    logic        rand_ready;
    logic        pend_write;
    logic        pend_read;
    logic [7:0]  pend_addr;
    word_t       pend_data;
    int          plen;
    reg_idx_t    last_dst, prev_dst;
    int          mismatches, failures;
    logic        aborted;

    cpu dut_i (.*);

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // random source and program encoding

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [15:0] take_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic inst_t enc_r(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, fn};
    endfunction

    function automatic inst_t enc_i(logic [3:0] op, reg_idx_t rs, reg_idx_t rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic emit(input inst_t inst);
        imem[plen] = inst;
        plen++;
    endtask

    // mode 0 alu only, 1 chained operands, 2 memory pairs, 3 everything
    task automatic gen_program(input int mode);
        reg_idx_t   rs, rt, rd, dst;
        logic [7:0] imm;
        int         kind;
        for (int i = 0; i < 256; i++) begin
            imem[i]      = enc_r(reg_idx_t'(i), 2'd0, 2'd0, `FN_WWD);   // dead code past hlt
            dmem_init[i] = take_bits(16);
        end
        plen     = 0;
        last_dst = 2'd0;
        prev_dst = 2'd1;
        for (int n = 0; n < PROG_LEN; n++) begin
            rs  = reg_idx_t'(take_bits(2));
            rt  = reg_idx_t'(take_bits(2));
            rd  = reg_idx_t'(take_bits(2));
            imm = 8'(take_bits(8));
            case (mode)
                0, 1:    kind = int'(take_bits(4)) % 11;
                2:       kind = 11 + int'(take_bits(3)) % 5;
                default: kind = int'(take_bits(4));
            endcase
            if (mode == 1) begin
                rs = last_dst;
                rt = prev_dst;
            end
            dst = rt;
            case (kind)
                8:  emit(enc_i(`OP_ADI, rs, rt, imm));
                9:  emit(enc_i(`OP_ORI, rs, rt, imm));
                10: emit(enc_i(`OP_LHI, rs, rt, imm));
                11: emit(enc_i(`OP_LWD, rs, rt, imm));
                12: begin
                    emit(enc_i(`OP_SWD, rs, rt, imm));
                    dst = last_dst;
                end
                13: begin
                    emit(enc_r(rs, rt, rd, `FN_WWD));
                    dst = last_dst;
                end
                14: begin   // store then load back
                    emit(enc_i(`OP_SWD, rs, rt, imm));
                    emit(enc_i(`OP_LWD, rs, rd, imm));
                    dst = rd;
                end
                15: begin   // load used at once
                    emit(enc_i(`OP_LWD, rs, rt, imm));
                    emit(enc_r(rt, rt, rd, `FN_ADD));
                    dst = rd;
                end
                default: begin
                    emit(enc_r(rs, rt, rd, 6'(kind)));
                    dst = rd;
                end
            endcase
            prev_dst = last_dst;
            last_dst = dst;
        end
        for (int r = 0; r < `NUM_REGS; r++) begin
            emit(enc_r(reg_idx_t'(r), 2'd0, 2'd0, `FN_WWD));
        end
        emit(enc_r(2'd0, 2'd0, 2'd0, `FN_HLT));
    endtask

    ////////////////////////////////////////////////////////////
    // in-order ISA model

    task automatic run_model();
        word_t r [`NUM_REGS];
        word_t a, b, sext, addr, out;
        inst_t inst;
        int    pc;
        logic  done;
        for (int i = 0; i < 256; i++) begin
            model_mem[i] = dmem_init[i];
        end
        for (int i = 0; i < `NUM_REGS; i++) begin
            r[i] = '0;
        end
        model_count  = 0;
        model_stores = 0;
        model_loads  = 0;
        out  = '0;
        pc   = 0;
        done = 1'b0;
        while (!done && pc < 256) begin
            inst = imem[pc];
            pc++;
            a    = r[inst[11:10]];
            b    = r[inst[9:8]];
            sext = {{8{inst[7]}}, inst[7:0]};
            addr = a + sext;
            if (inst[15:12] == `OP_RTYPE && inst[5:0] == `FN_HLT) begin
                done = 1'b1;
            end else begin
                case (inst[15:12])
                    `OP_RTYPE: begin
                        case (inst[5:0])
                            `FN_ADD: r[inst[7:6]] = a + b;
                            `FN_SUB: r[inst[7:6]] = a - b;
                            `FN_AND: r[inst[7:6]] = a & b;
                            `FN_ORR: r[inst[7:6]] = a | b;
                            `FN_NOT: r[inst[7:6]] = ~a;
                            `FN_TCP: r[inst[7:6]] = ~a + word_t'(1);
                            `FN_SHL: r[inst[7:6]] = a << 1;
                            `FN_SHR: r[inst[7:6]] = {a[15], a[15:1]};
                            `FN_WWD: out = a;
                            default: ;
                        endcase
                    end
                    `OP_ADI: r[inst[9:8]] = a + sext;
                    `OP_ORI: r[inst[9:8]] = a | {8'h00, inst[7:0]};
                    `OP_LHI: r[inst[9:8]] = {inst[7:0], 8'h00};
                    `OP_LWD: begin
                        r[inst[9:8]] = model_mem[addr[7:0]];
                        model_loads++;
                    end
                    `OP_SWD: begin
                        model_mem[addr[7:0]] = b;
                        model_stores++;
                    end
                    default: ;
                endcase
                model_count++;
                retire_out[model_count] = out;
            end
        end
        final_out = out;
    endtask

    ////////////////////////////////////////////////////////////
    // compare tasks

    task automatic check_output(input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH output_port got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    task automatic check_count(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_mem(input int idx, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH dmem[%h] got %h expected %h", idx[7:0], got, exp);
        end
    endtask

    task automatic check_fetch_addr(input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH address1 got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // memory models driven on the falling edge

    always @(negedge clk) begin
        if (pend_write) begin   // store taken at the last rising edge
            dmem[pend_addr] = pend_data;
            store_count++;
        end
        if (pend_read) begin    // load taken at the last rising edge
            load_count++;
        end
        m1_ready   = rand_ready ? (take_bits(2) != 16'd0) : 1'b1;
        m2_ready   = rand_ready ? (take_bits(2) != 16'd0) : 1'b1;
        data1      = imem[address1[7:0]];
        read_data  = dmem[address2[7:0]];
        pend_write = write_m2 && m2_ready && !reset_n;
        pend_read  = read_m2 && m2_ready && !reset_n;
        pend_addr  = address2[7:0];
        pend_data  = write_data;
    end

    task automatic load_dmem();
        for (int i = 0; i < 256; i++) begin
            dmem[i] = dmem_init[i];
        end
        pend_write  = 1'b0;
        pend_read   = 1'b0;
        store_count = 0;
        load_count  = 0;
    endtask

    task automatic apply_reset();
        reset_n = 1'b1;
        @(negedge clk);
        check_count("num_inst", num_inst, '0);
        check_output(output_port, '0);
        if (is_halted) begin
            failures++;
            $display("is_halted still high during reset at %0t", $time);
        end
        @(negedge clk);
        load_dmem();
        reset_n = 1'b0;
    endtask

    task automatic wait_halt();
        int    cycles;
        word_t seen;
        cycles = 0;
        seen   = '0;
        while (!is_halted && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (num_inst != seen) begin
                check_count("num_inst", num_inst, seen + word_t'(1));
                seen = num_inst;
                if (int'(seen) <= model_count) begin
                    check_output(output_port, retire_out[seen[7:0]]);
                end
            end
        end
        if (!is_halted) begin
            failures++;
            aborted = 1'b1;
            $display("timeout: is_halted did not rise within %0d cycles", TIMEOUT);
        end else begin
            repeat (20) begin   // nothing may retire past hlt
                @(negedge clk);
                if (!is_halted) begin
                    failures++;
                    $display("is_halted dropped after halt at %0t", $time);
                end
                check_output(output_port, final_out);
            end
            check_count("num_inst", num_inst, word_t'(model_count));
            check_count("store count", word_t'(store_count), word_t'(model_stores));
            check_count("load count", word_t'(load_count), word_t'(model_loads));
            for (int i = 0; i < 256; i++) begin
                check_mem(i, dmem[i], model_mem[i]);
            end
        end
    endtask

    task automatic verify_run();
        int cycles;
        cycles = 0;
        while (!read_m1 && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!read_m1) begin
            failures++;
            aborted = 1'b1;
            $display("timeout: no instruction fetch after reset");
        end else begin
            check_fetch_addr(address1, '0);
            wait_halt();
        end
    endtask

    task automatic run_case(input int t);
        gen_program(t < 3 ? t : 3);
        run_model();
        rand_ready = (t >= 3);
        apply_reset();
        if (t == 5) begin
            repeat (25) @(negedge clk);   // reset again mid-program
            apply_reset();
        end
        verify_run();
    endtask

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b1;
        m1_ready    = 1'b0;
        m2_ready    = 1'b0;
        data1       = `NOP_INST;
        read_data   = '0;
        lfsr        = 32'hf1a5;
        rand_ready  = 1'b0;
        pend_write  = 1'b0;
        pend_read   = 1'b0;
        store_count = 0;
        load_count  = 0;
        mismatches  = 0;
        failures    = 0;
        aborted     = 1'b0;
        for (int t = 0; t < 6 && !aborted; t++) begin
            run_case(t);
        end
        $display("mismatches %0d, other failures %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/register_file.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/mem_wb_unit.sv
verilog/cpu.sv
verif/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the cpu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -f filelist.f -o cpu_sim

./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log

grep -qx "sim passed" sim.log
